// ==== flist.f ====
+incdir+rtl
rtl/div_pkg.sv
rtl/div_tag_if.sv
rtl/div_array.sv
rtl/div_tag_pipe.sv
rtl/div_result_sel.sv
rtl/div_top.sv
test/div_top_tb.sv

// ==== rtl/div_array.sv ====
`timescale 1ns/10ps
`include "div_macros.svh"

module div_array (
    input  logic           clk,
    input  div_pkg::data_t dividend,
    input  div_pkg::data_t divisor,
    output div_pkg::data_t quotient,
    output div_pkg::data_t remainder
);
    import div_pkg::*;

    localparam int W = `DIV_WIDTH;

    // Upper half is the partial remainder. The lower half holds the dividend bits
    // not yet consumed, with the quotient bits filling in from the bottom
    logic [2*W-1:0] rem_q [0:`DIV_STAGES];
    logic [2*W-1:0] rem_d [1:`DIV_STAGES];
    data_t          div_q [0:`DIV_STAGES-1];

    genvar i;
    generate
        for (i = 0; i < `DIV_STAGES; i++) begin : g_stage
            logic [W:0] trial;  // Shifted partial remainder including its carry bit
            data_t      diff;
            logic       fits;

            // The shifted remainder can reach 2*divisor-1 and so needs the extra bit
            assign trial = rem_q[i][2*W-1:W-1];
            assign fits  = trial >= {1'b0, div_q[i]};

            // When the divisor fits the difference is below the divisor, so the
            // low W bits of the subtraction are the full answer
            assign diff  = trial[W-1:0] - div_q[i];

            assign rem_d[i+1] = fits ? {diff, rem_q[i][W-2:0], 1'b1}
                                     : {rem_q[i][2*W-2:0], 1'b0};
        end
    endgenerate

    // Stage 0 only captures the operands; stages 1 to DIV_STAGES each retire
    // one quotient bit
    always_ff @(posedge clk) begin
        rem_q[0] <= {{W{1'b0}}, dividend};
        div_q[0] <= divisor;

        for (int s = 1; s <= `DIV_STAGES; s++) begin
            rem_q[s] <= rem_d[s];
        end

        for (int s = 1; s < `DIV_STAGES; s++) begin
            div_q[s] <= div_q[s-1];  // Last stage reads div_q[DIV_STAGES-1]
        end
    end

    // A zero divisor always fits, which leaves all ones in the quotient and the
    // dividend in the remainder
    assign quotient  = rem_q[`DIV_STAGES][W-1:0];
    assign remainder = rem_q[`DIV_STAGES][2*W-1:W];

endmodule

// ==== rtl/div_macros.svh ====
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// Operand, quotient and remainder width
`define DIV_WIDTH       32

// One compare-subtract-shift stage per quotient bit
`define DIV_STAGES      `DIV_WIDTH

`define DIV_ADDR_WIDTH  8
`define DIV_PC_WIDTH    32
`define DIV_OP_WIDTH    4

`endif

// ==== rtl/div_pkg.sv ====
`include "div_macros.svh"

package div_pkg;

    typedef logic [`DIV_WIDTH-1:0]      data_t;
    typedef logic [`DIV_ADDR_WIDTH-1:0] addr_t;  // Physical destination register
    typedef logic [`DIV_PC_WIDTH-1:0]   pc_t;

    // Only two codes are legal on the issue port
    typedef enum logic [`DIV_OP_WIDTH-1:0] {
        OP_QUOTIENT  = 4'd1,
        OP_REMAINDER = 4'd2
    } div_op_e;

endpackage

// ==== rtl/div_result_sel.sv ====
`timescale 1ns/10ps

module div_result_sel (
    input  logic           clk,
    input  logic           reset,
    div_tag_if.sink        tag,
    input  div_pkg::data_t quotient,
    input  div_pkg::data_t remainder,
    output logic           out_valid,
    output div_pkg::data_t result,
    output div_pkg::addr_t phys_addr_out,
    output div_pkg::pc_t   pc_out
);
    import div_pkg::*;

    logic  want_quotient;
    data_t result_d;

    assign want_quotient = (tag.op == OP_QUOTIENT);
    assign result_d      = want_quotient ? quotient : remainder;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= tag.valid;  // One pulse per retired operation
        end
    end

    always_ff @(posedge clk) begin
        result        <= result_d;
        phys_addr_out <= tag.addr;
        pc_out        <= tag.pc;
    end

    // The opcode was sampled 33 cycles earlier at the top-level issue port
    a_op_legal: assert property (@(posedge clk) disable iff (reset)
        tag.valid |-> (tag.op inside {OP_QUOTIENT, OP_REMAINDER}))
        else $error("div_result_sel: illegal opcode %0h on a valid slot", tag.op);

endmodule

// ==== rtl/div_tag_if.sv ====
`timescale 1ns/10ps

// Bookkeeping that travels alongside one division

interface div_tag_if;
    import div_pkg::*;

    logic    valid;  // Qualifies the other three fields
    addr_t   addr;
    pc_t     pc;
    div_op_e op;

    modport source (
        output valid,
        output addr,
        output pc,
        output op
    );

    modport sink (
        input valid,
        input addr,
        input pc,
        input op
    );
endinterface

// ==== rtl/div_tag_pipe.sv ====
`timescale 1ns/10ps
`include "div_macros.svh"

module div_tag_pipe (
    input logic       clk,
    input logic       reset,
    div_tag_if.sink   tag_in,
    div_tag_if.source tag_out
);
    import div_pkg::*;

    // Same register count as the array, so entry DIV_STAGES pairs with its result
    logic    valid_q [0:`DIV_STAGES];
    addr_t   addr_q  [0:`DIV_STAGES];
    pc_t     pc_q    [0:`DIV_STAGES];
    div_op_e op_q    [0:`DIV_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s <= `DIV_STAGES; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else begin
            valid_q[0] <= tag_in.valid;
            for (int s = 1; s <= `DIV_STAGES; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Tags shift every cycle whether or not the slot is valid
    always_ff @(posedge clk) begin
        addr_q[0] <= tag_in.addr;
        pc_q[0]   <= tag_in.pc;
        op_q[0]   <= tag_in.op;
        for (int s = 1; s <= `DIV_STAGES; s++) begin
            addr_q[s] <= addr_q[s-1];
            pc_q[s]   <= pc_q[s-1];
            op_q[s]   <= op_q[s-1];
        end
    end

    assign tag_out.valid = valid_q[`DIV_STAGES];
    assign tag_out.addr  = addr_q[`DIV_STAGES];
    assign tag_out.pc    = pc_q[`DIV_STAGES];
    assign tag_out.op    = op_q[`DIV_STAGES];

    // Once reset has flushed the chain, an X here means the issue side drove one
    a_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(tag_out.valid))
        else $error("div_tag_pipe: valid at the pipe output is unknown");

endmodule

// ==== rtl/div_top.sv ====
`timescale 1ns/10ps

module div_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  div_pkg::data_t    dividend,
    input  div_pkg::data_t    divisor,
    input  div_pkg::addr_t    phys_addr_in,
    input  div_pkg::pc_t      pc_in,
    input  div_pkg::div_op_e  div_op,
    output logic              out_valid,
    output div_pkg::data_t    result,
    output div_pkg::addr_t    phys_addr_out,
    output div_pkg::pc_t      pc_out
);
    import div_pkg::*;

    data_t quotient;
    data_t remainder;

    div_tag_if tag_in ();
    div_tag_if tag_out ();

    // Issue side of the tag pipe with no handshake beyond the valid pulse
    assign tag_in.valid = in_valid;
    assign tag_in.addr  = phys_addr_in;
    assign tag_in.pc    = pc_in;
    assign tag_in.op    = div_op;

    // Operands never stall, so the array needs no valid of its own
    div_array div_array_inst (
        .clk       (clk),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_tag_pipe div_tag_pipe_inst (
        .clk     (clk),
        .reset   (reset),
        .tag_in  (tag_in.sink),
        .tag_out (tag_out.source)
    );

    div_result_sel div_result_sel_inst (
        .clk           (clk),
        .reset         (reset),
        .tag           (tag_out.sink),
        .quotient      (quotient),
        .remainder     (remainder),
        .out_valid     (out_valid),
        .result        (result),
        .phys_addr_out (phys_addr_out),
        .pc_out        (pc_out)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the divider testbench with Verilator, runs it and scans the log

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f flist.f \
    --top-module div_top_tb \
    -Mdir "$OBJ_DIR" \
    -o Vdiv_top_tb
if [ $? -ne 0 ]; then
    echo "Build with Verilator did not succeed"
    exit 1
fi

"./$OBJ_DIR/Vdiv_top_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi

exit 0

// ==== test/div_top_tb.sv ====
`timescale 1ns/10ps

module div_top_tb;
    import div_pkg::*;

    logic    clk;
    logic    reset;
    logic    in_valid;
    data_t   dividend;
    data_t   divisor;
    addr_t   phys_addr_in;
    pc_t     pc_in;
    div_op_e div_op;
    logic    out_valid;
    data_t   result;
    addr_t   phys_addr_out;
    pc_t     pc_out;

    // Scoreboard with the oldest outstanding operation at the front
    data_t exp_result_q[$];
    addr_t exp_addr_q[$];
    pc_t   exp_pc_q[$];

    int errors = 0;
    int results_done = 0;
    int run_len = 0;
    int longest_run = 0;  // Longest stretch of back-to-back results
    logic [31:0] rand_state = 32'hb5d66310;

    div_top div_top_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .dividend      (dividend),
        .divisor       (divisor),
        .phys_addr_in  (phys_addr_in),
        .pc_in         (pc_in),
        .div_op        (div_op),
        .out_valid     (out_valid),
        .result        (result),
        .phys_addr_out (phys_addr_out),
        .pc_out        (pc_out)
    );

    always #5 clk = ~clk;

    // Integer division with the restoring algorithm's answer for a zero divisor
    function automatic data_t expected_result(input data_t a, input data_t b,
                                              input div_op_e op);
        if (b == 32'h0) begin
            if (op == OP_QUOTIENT) return 32'hFFFF_FFFF;
            return a;
        end
        if (op == OP_QUOTIENT) return a / b;
        return a % b;
    endfunction

    function logic [31:0] xorshift32();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // Called on a falling edge and returns on the next one
    task automatic issue(input data_t a, input data_t b, input div_op_e op,
                         input addr_t addr, input pc_t pc);
        in_valid     = 1'b1;
        dividend     = a;
        divisor      = b;
        div_op       = op;
        phys_addr_in = addr;
        pc_in        = pc;
        exp_result_q.push_back(expected_result(a, b, op));
        exp_addr_q.push_back(addr);
        exp_pc_q.push_back(pc);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Queue size is read on the rising edge away from the monitor's pops
    task automatic drain();
        int i;
        for (i = 0; i < 200 && exp_result_q.size() > 0; i++) begin
            @(posedge clk);
        end
        if (exp_result_q.size() > 0) begin
            $display("Timeout: %0d results still missing after 200 cycles",
                     exp_result_q.size());
            errors++;
            exp_result_q.delete();
            exp_addr_q.delete();
            exp_pc_q.delete();
        end
        @(negedge clk);
    endtask

    always @(negedge clk) begin : monitor
        data_t exp_res;
        addr_t exp_addr;
        pc_t   exp_pc;
        if (!reset) begin
            if ($isunknown(out_valid)) begin
                $display("out_valid is unknown after reset");
                errors++;
            end else if (out_valid) begin
                run_len++;
                if (run_len > longest_run) longest_run = run_len;
                results_done++;
                if (exp_result_q.size() == 0) begin
                    $display("A result came out with no operation outstanding");
                    errors++;
                end else begin
                    exp_res  = exp_result_q.pop_front();
                    exp_addr = exp_addr_q.pop_front();
                    exp_pc   = exp_pc_q.pop_front();
                    if (result !== exp_res) begin
                        $display("ERROR: result expected %h got %h", exp_res, result);
                        errors++;
                    end
                    if (phys_addr_out !== exp_addr) begin
                        $display("ERROR: phys_addr_out expected %h got %h",
                                 exp_addr, phys_addr_out);
                        errors++;
                    end
                    if (pc_out !== exp_pc) begin
                        $display("ERROR: pc_out expected %h got %h", exp_pc, pc_out);
                        errors++;
                    end
                end
            end else begin
                run_len = 0;
            end
        end
    end

    task automatic check_reset();
        int i;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("ERROR: out_valid expected %h got %h during reset", 1'b0, out_valid);
                errors++;
            end
        end
        reset = 1'b0;
    endtask

    data_t pair_a[5] = '{32'd100, 32'hFFFF_FFFF, 32'd5, 32'hDEAD_BEEF, 32'h8000_0000};
    data_t pair_b[5] = '{32'd7, 32'd1, 32'd9, 32'h0000_1234, 32'hFFFF_FFFF};

    task automatic divide_fixed_pairs(input div_op_e op);
        int i;
        for (i = 0; i < 5; i++) begin
            issue(pair_a[i], pair_b[i], op, 8'h10 + 8'(i), 32'h0000_1000 + 32'(i * 4));
        end
        drain();
    endtask

    task automatic divide_by_zero();
        issue(32'd100, 32'd0, OP_QUOTIENT, 8'h20, 32'h0000_2000);
        issue(32'd100, 32'd0, OP_REMAINDER, 8'h21, 32'h0000_2004);
        issue(32'h0, 32'd0, OP_QUOTIENT, 8'h22, 32'h0000_2008);
        issue(32'hCAFE_F00D, 32'd0, OP_REMAINDER, 8'h23, 32'h0000_200C);
        drain();
    endtask

    task automatic stream_random_ops();
        data_t       a;
        data_t       b;
        logic [31:0] r;
        div_op_e     op;
        int          start_done;
        int          i;
        longest_run = 0;  // Pipeline is empty here, so the monitor is idle
        start_done  = results_done;
        for (i = 0; i < 64; i++) begin
            a = xorshift32();
            r = xorshift32();
            b = xorshift32() >> r[4:0];  // Spread the divisor over many sizes
            if (r[5]) op = OP_QUOTIENT;
            else op = OP_REMAINDER;
            issue(a, b, op, r[15:8], xorshift32());
        end
        drain();
        if (results_done - start_done != 64) begin
            $display("ERROR: result count expected %h got %h", 64, results_done - start_done);
            errors++;
        end
        if (longest_run != 64) begin
            $display("Streamed results were not returned one per cycle (longest run %0d)",
                     longest_run);
            errors++;
        end
    endtask

    // Cycle j counts rising edges after the one that sampled the operation
    task automatic measure_latency();
        int j;
        issue(32'd1000, 32'd10, OP_QUOTIENT, 8'h5A, 32'h0000_3000);
        for (j = 0; j <= 40; j++) begin
            if (out_valid !== (j == 33)) begin
                $display("ERROR: out_valid expected %h got %h at cycle %0d",
                         (j == 33), out_valid, j);
                errors++;
            end
            @(negedge clk);
        end
        drain();
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        dividend     = 32'h0;
        divisor      = 32'h0;
        phys_addr_in = 8'h0;
        pc_in        = 32'h0;
        div_op       = OP_QUOTIENT;

        check_reset();
        divide_fixed_pairs(OP_QUOTIENT);
        divide_fixed_pairs(OP_REMAINDER);
        divide_by_zero();
        stream_random_ops();
        measure_latency();

        $display("Results: %0d, errors: %0d", results_done, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
